//--- include/lsq_defines.svh
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// store queue
`define LSQ_DEPTH        8
`define LSQ_PTR_W        3

// store record fields
`define LSQ_ADDR_W       32
`define LSQ_SZ_W         3
`define LSQ_DATA_W       128

// data cache banking, 4 bytes per bank
`define LSQ_BANKS        32
`define LSQ_BANK_W       5

// aligned write data covers up to five bank words
`define LSQ_LANE_DATA_W  160

`endif

//--- hw/lsq_pkg.sv
`include "lsq_defines.svh"

package lsq_pkg;

  // addr[1:0] is the byte offset, addr[6:2] the begin bank
  typedef struct packed {
    logic [`LSQ_ADDR_W-1:0] addr;
    logic [`LSQ_SZ_W-1:0]   sz;     // 0..4 -> 1,2,4,8,16 bytes
    logic [`LSQ_DATA_W-1:0] data;
  } store_rec_t;

  typedef struct packed {
    logic       en;
    store_rec_t rec;
  } store_in_t;

  typedef struct packed {
    logic bus_hold;
    logic miss_hold;
    logic miss_pause;
    logic insert_hold;
  } hold_t;

  typedef struct packed {
    logic       en;
    store_rec_t rec;
  } wreq_t;

  typedef struct packed {
    logic                        en;
    logic [`LSQ_ADDR_W-1:0]      addr;
    logic [`LSQ_BANK_W-1:0]      bank1;    // end bank
    logic [3:0]                  bgn_ben;
    logic [3:0]                  end_ben;
    logic [`LSQ_LANE_DATA_W-1:0] data;
  } st_port_t;

  // offset of the last byte written, counted from the begin bank
  function automatic logic [4:0] last_off(logic [1:0] low, logic [`LSQ_SZ_W-1:0] sz);
    logic [4:0] nbytes;
    nbytes = sz[2] ? 5'd16 : (5'd1 << sz[1:0]); // codes above 4 act as 16 bytes
    return {3'b000, low} + nbytes - 5'd1;
  endfunction

endpackage

//--- hw/store_queue.sv
`timescale 1ns/100ps
`include "lsq_defines.svh"

module store_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  lsq_pkg::store_in_t  store_in,
  input  logic [1:0]          pop,
  input  logic [3:0]          stall_rs,
  input  logic                stall_alloc,
  output lsq_pkg::store_rec_t head0,
  output lsq_pkg::store_rec_t head1,
  output logic [1:0]          head_valid,
  output logic                do_stall,
  output logic                stall_cntrl
);

  lsq_pkg::store_rec_t mem [`LSQ_DEPTH];

  logic [`LSQ_PTR_W-1:0] wr_ptr;
  logic [`LSQ_PTR_W-1:0] rd_ptr;
  logic [`LSQ_PTR_W-1:0] rd_nxt;
  logic [`LSQ_PTR_W:0]   count;
  logic [`LSQ_PTR_W:0]   n_push;
  logic [`LSQ_PTR_W:0]   n_pop;
  logic [1:0]            pop_cnt;
  logic                  full;
  logic                  accept;

  assign full   = count == `LSQ_DEPTH;
  assign accept = store_in.en & ~full;  // dropped silently when full

  // pop[1] only comes with pop[0]
  assign pop_cnt = {1'b0, pop[0]} + {1'b0, pop[1]};

  assign n_push = {{`LSQ_PTR_W{1'b0}}, accept};
  assign n_pop  = {{(`LSQ_PTR_W-1){1'b0}}, pop_cnt};

  assign rd_nxt = rd_ptr + 1'b1;   // wraps with the pointer

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept)
        wr_ptr <= wr_ptr + 1'b1;
      rd_ptr <= rd_ptr + n_pop[`LSQ_PTR_W-1:0];
      count  <= count + n_push - n_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      mem[wr_ptr] <= store_in.rec;
  end

  // two oldest entries, head1 behind head0
  assign head0 = mem[rd_ptr];
  assign head1 = mem[rd_nxt];

  assign head_valid[0] = count != '0;
  assign head_valid[1] = count > 1;

  assign do_stall = full;

  // controller sees every stall source at once
  assign stall_cntrl = |{stall_rs, stall_alloc, do_stall};

endmodule

//--- hw/store_pick.sv
`timescale 1ns/100ps
`include "lsq_defines.svh"

module store_pick (
  input  logic                clk,
  input  logic                rst_n,
  input  lsq_pkg::store_rec_t head0,
  input  lsq_pkg::store_rec_t head1,
  input  logic [1:0]          head_valid,
  input  lsq_pkg::hold_t      hold,
  input  logic                st_stall,
  output logic [1:0]          pop,
  output lsq_pkg::wreq_t      wreq0,
  output lsq_pkg::wreq_t      wreq1
);

  // banks touched by one store, wrapping past the last bank
  function automatic logic [`LSQ_BANKS-1:0] bank_mask(lsq_pkg::store_rec_t rec);
    logic [4:0]              last;
    logic [2:0]              nbanks;
    logic [`LSQ_BANKS-1:0]   run;
    logic [2*`LSQ_BANKS-1:0] rot;
    last   = lsq_pkg::last_off(rec.addr[1:0], rec.sz);
    nbanks = last[4:2] + 3'd1;
    run    = ~({`LSQ_BANKS{1'b1}} << nbanks);
    rot    = {{`LSQ_BANKS{1'b0}}, run} << rec.addr[`LSQ_BANK_W+1:2];
    return rot[`LSQ_BANKS-1:0] | rot[2*`LSQ_BANKS-1:`LSQ_BANKS];
  endfunction

  logic                  st_stall_q;
  logic                  issue_stall;
  logic [`LSQ_BANKS-1:0] mask0;
  logic [`LSQ_BANKS-1:0] mask1;
  logic                  grant0;
  logic                  grant1;
  logic [1:0]            en_q;

  lsq_pkg::store_rec_t rec0_q;
  lsq_pkg::store_rec_t rec1_q;

  assign issue_stall = hold.bus_hold | hold.miss_hold | hold.miss_pause |
                       hold.insert_hold | st_stall_q;

  assign mask0 = bank_mask(head0);
  assign mask1 = bank_mask(head1);

  assign grant0 = head_valid[0] & ~issue_stall;
  assign grant1 = grant0 & head_valid[1] & ((mask0 & mask1) == '0); // no shared bank

  assign pop = {grant1, grant0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_stall_q <= 1'b0;
      en_q       <= 2'b00;
    end else begin
      st_stall_q <= st_stall;
      en_q       <= {grant1, grant0};
    end
  end

  always_ff @(posedge clk) begin
    rec0_q <= head0;
    rec1_q <= head1;
  end

  assign wreq0.en  = en_q[0];
  assign wreq0.rec = rec0_q;
  assign wreq1.en  = en_q[1];
  assign wreq1.rec = rec1_q;

endmodule

//--- hw/store_lane.sv
`timescale 1ns/100ps
`include "lsq_defines.svh"

module store_lane (
  input  lsq_pkg::wreq_t    wreq,
  output lsq_pkg::st_port_t st
);

  logic [1:0]                  low;
  logic [`LSQ_BANK_W-1:0]      bank0;
  logic [4:0]                  last;
  logic [2:0]                  extra;    // banks past bank0
  logic [3:0]                  bgn_ben;
  logic [3:0]                  end_ben;
  logic [`LSQ_LANE_DATA_W-1:0] wide;

  assign low   = wreq.rec.addr[1:0];
  assign bank0 = wreq.rec.addr[`LSQ_BANK_W+1:2];
  assign last  = lsq_pkg::last_off(low, wreq.rec.sz);
  assign extra = last[4:2];

  assign wide = {{(`LSQ_LANE_DATA_W-`LSQ_DATA_W){1'b0}}, wreq.rec.data};

  // byte enables inside the first and the last bank word
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      bgn_ben[i] = (i >= int'(low)) && (i <= int'(last));
      end_ben[i] = i <= int'(last[1:0]);
    end
    if (extra == 3'd0)
      end_ben = bgn_ben;    // single bank store
  end

  assign st.en      = wreq.en;
  assign st.addr    = wreq.rec.addr;
  assign st.bank1   = bank0 + {2'b00, extra};  // wraps mod 32
  assign st.bgn_ben = bgn_ben;
  assign st.end_ben = end_ben;
  assign st.data    = wide << {low, 3'b000};

endmodule

//--- hw/lsq_store_top.sv
`timescale 1ns/100ps

module lsq_store_top (
  input  logic               clk,
  input  logic               rst_n,
  input  lsq_pkg::store_in_t store_in,
  input  lsq_pkg::hold_t     hold,
  input  logic               st_stall,
  input  logic [3:0]         stall_rs,
  input  logic               stall_alloc,
  output lsq_pkg::st_port_t  st0,
  output lsq_pkg::st_port_t  st1,
  output logic               do_stall,
  output logic               stall_cntrl
);

  lsq_pkg::store_rec_t head0;
  lsq_pkg::store_rec_t head1;
  logic [1:0]          head_valid;
  logic [1:0]          pop;
  lsq_pkg::wreq_t      wreq0;
  lsq_pkg::wreq_t      wreq1;

  store_queue u_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .store_in    (store_in),
    .pop         (pop),
    .stall_rs    (stall_rs),
    .stall_alloc (stall_alloc),
    .head0       (head0),
    .head1       (head1),
    .head_valid  (head_valid),
    .do_stall    (do_stall),
    .stall_cntrl (stall_cntrl)
  );

  // registered pick, lanes hang off its outputs
  store_pick u_pick (
    .clk        (clk),
    .rst_n      (rst_n),
    .head0      (head0),
    .head1      (head1),
    .head_valid (head_valid),
    .hold       (hold),
    .st_stall   (st_stall),
    .pop        (pop),
    .wreq0      (wreq0),
    .wreq1      (wreq1)
  );

  store_lane lane0 (
    .wreq (wreq0),
    .st   (st0)
  );

  store_lane lane1 (   // younger store
    .wreq (wreq1),
    .st   (st1)
  );

endmodule

//--- include/tb_store_model.svh
`ifndef TB_STORE_MODEL_SVH
`define TB_STORE_MODEL_SVH

// expected stores in issue order, with the cycle each was driven in
lsq_pkg::store_rec_t exp_q[$];
int                  drv_cyc_q[$];

function automatic int size_bytes(logic [2:0] sz);
  case (sz)
    3'd0:    return 1;
    3'd1:    return 2;
    3'd2:    return 4;
    3'd3:    return 8;
    default: return 16;
  endcase
endfunction

function automatic int last_byte(lsq_pkg::store_rec_t r);
  return int'(r.addr[1:0]) + size_bytes(r.sz) - 1;
endfunction

function automatic logic [4:0] end_bank(lsq_pkg::store_rec_t r);
  return 5'((int'(r.addr[6:2]) + last_byte(r) / 4) % `LSQ_BANKS);
endfunction

function automatic logic [3:0] first_ben(lsq_pkg::store_rec_t r);
  logic [3:0] ben;
  int         lo;
  int         hi;
  lo = int'(r.addr[1:0]);
  hi = (last_byte(r) < 3) ? last_byte(r) : 3;
  for (int i = 0; i < 4; i++)
    ben[i] = (i >= lo) && (i <= hi);
  return ben;
endfunction

function automatic logic [3:0] last_ben(lsq_pkg::store_rec_t r);
  logic [3:0] ben;
  if (last_byte(r) / 4 == 0)
    return first_ben(r);   // fits in one bank
  for (int i = 0; i < 4; i++)
    ben[i] = i <= last_byte(r) % 4;
  return ben;
endfunction

function automatic logic [`LSQ_LANE_DATA_W-1:0] aligned_data(lsq_pkg::store_rec_t r);
  logic [`LSQ_LANE_DATA_W-1:0] w;
  w = `LSQ_LANE_DATA_W'(r.data);
  return w << (8 * int'(r.addr[1:0]));
endfunction

// true when the two stores touch a common bank
function automatic bit spans_overlap(lsq_pkg::store_rec_t a, lsq_pkg::store_rec_t b);
  for (int i = 0; i <= last_byte(a) / 4; i++)
    for (int j = 0; j <= last_byte(b) / 4; j++)
      if ((int'(a.addr[6:2]) + i) % `LSQ_BANKS == (int'(b.addr[6:2]) + j) % `LSQ_BANKS)
        return 1'b1;
  return 1'b0;
endfunction

`endif

//--- test/tb_lsq_store.sv
`timescale 1ns/100ps
`include "lsq_defines.svh"

module tb_lsq_store;

  localparam int CLK_HALF = 20;
  // reset plus the fixed test lengths
  localparam int TEST_CYCLES = 4 + 10 + 80 + 60 + 100 + 12;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 600) * 2 * CLK_HALF;  // drains fit in the margin

  logic                clk = 1'b0;
  logic                rst_n = 1'b0;
  lsq_pkg::store_in_t  store_in;
  lsq_pkg::hold_t      hold;
  logic                st_stall;
  logic [3:0]          stall_rs;
  logic                stall_alloc;
  lsq_pkg::st_port_t   st0;
  lsq_pkg::st_port_t   st1;
  logic                do_stall;
  logic                stall_cntrl;

  integer seed = 77106;
  int     cyc = 0;
  int     errors = 0;
  int     checks = 0;
  int     n_accepted = 0;
  int     tests_run = 0;
  int     test_err0 = 0;
  logic   hold_d1 = 1'b0;
  logic   stst_d1 = 1'b0;
  logic   stst_d2 = 1'b0;

  `include "tb_store_model.svh"

  lsq_store_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .store_in    (store_in),
    .hold        (hold),
    .st_stall    (st_stall),
    .stall_rs    (stall_rs),
    .stall_alloc (stall_alloc),
    .st0         (st0),
    .st1         (st1),
    .do_stall    (do_stall),
    .stall_cntrl (stall_cntrl)
  );

  always #(CLK_HALF) clk = ~clk;

  // stall history seen by the pick stage
  always @(posedge clk) begin
    cyc     <= cyc + 1;
    hold_d1 <= |hold;
    stst_d1 <= st_stall;
    stst_d2 <= stst_d1;
  end

  task automatic compare_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %0h expected %0h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic check_port(input string name, input lsq_pkg::st_port_t p,
                            input lsq_pkg::store_rec_t r);
    compare_value({name, ".addr"}, 160'(p.addr), 160'(r.addr));
    compare_value({name, ".bank1"}, 160'(p.bank1), 160'(end_bank(r)));
    compare_value({name, ".bgn_ben"}, 160'(p.bgn_ben), 160'(first_ben(r)));
    compare_value({name, ".end_ben"}, 160'(p.end_ben), 160'(last_ben(r)));
    compare_value({name, ".data"}, 160'(p.data), 160'(aligned_data(r)));
  endtask

  // outputs settle by mid-cycle
  task automatic check_outputs();
    lsq_pkg::store_rec_t r0;
    lsq_pkg::store_rec_t r1;
    logic                exp_en0;
    logic                exp_en1;
    int                  occ;
    exp_en0 = (exp_q.size() > 0) && !hold_d1 && !stst_d2;
    if (exp_en0)
      exp_en0 = drv_cyc_q[0] <= cyc - 2;
    exp_en1 = 1'b0;
    compare_value("st0.en", 160'(st0.en), 160'(exp_en0));
    if (st0.en && exp_q.size() > 0) begin
      r0 = exp_q.pop_front();
      drv_cyc_q.delete(0);
      check_port("st0", st0, r0);
      if (exp_q.size() > 0)
        exp_en1 = (drv_cyc_q[0] <= cyc - 2) && !spans_overlap(r0, exp_q[0]);
    end
    compare_value("st1.en", 160'(st1.en), 160'(exp_en1));
    if (st1.en && exp_q.size() > 0) begin
      r1 = exp_q.pop_front();
      drv_cyc_q.delete(0);
      check_port("st1", st1, r1);
    end
    occ = 0;
    foreach (drv_cyc_q[i])
      if (drv_cyc_q[i] <= cyc - 1)
        occ++;
    compare_value("do_stall", 160'(do_stall), 160'(occ == `LSQ_DEPTH));
    compare_value("stall_cntrl", 160'(stall_cntrl),
                  160'((|stall_rs) | stall_alloc | (occ == `LSQ_DEPTH)));
  endtask

  always @(negedge clk)
    if (rst_n)
      check_outputs();

  task automatic drive_cycle(input bit want_store, input lsq_pkg::hold_t h, input bit sst,
                             input logic [31:0] addr_mask);
    lsq_pkg::store_rec_t r;
    @(posedge clk);
    #2;
    hold        = h;
    st_stall    = sst;
    stall_rs    = 4'($random(seed));
    stall_alloc = 1'($random(seed));
    if (want_store && !do_stall) begin   // source obeys do_stall
      r.addr = $random(seed) & addr_mask;
      r.sz   = 3'($unsigned($random(seed)) % 5);
      r.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      store_in.en  = 1'b1;
      store_in.rec = r;
      exp_q.push_back(r);
      drv_cyc_q.push_back(cyc);
      n_accepted++;
    end else begin
      store_in.en = 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_q.size() > 0)
      drive_cycle(1'b0, '0, 1'b0, '1);
    repeat (3)
      drive_cycle(1'b0, '0, 1'b0, '1);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s done, %0d errors", tests_run, name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin
    lsq_pkg::hold_t h;
    int             acc0;
    store_in    = '0;
    hold        = '0;
    st_stall    = 1'b0;
    stall_rs    = 4'h0;
    stall_alloc = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;

    repeat (10)
      drive_cycle(1'b0, '0, 1'b0, '1);
    finish_test("reset_idle");

    for (int i = 0; i < 80; i++)
      drive_cycle(($unsigned($random(seed)) % 3) == 0, '0, 1'b0, '1);
    drain();
    finish_test("single_stores");

    // short bus holds build a backlog
    for (int i = 0; i < 60; i++) begin
      h = '0;
      h.bus_hold = (i % 8) < 3;
      drive_cycle(1'b1, h, 1'b0, 32'h0000_001f);  // low banks overlap often
    end
    drain();
    finish_test("dual_issue");

    for (int i = 0; i < 100; i++) begin
      h = '0;
      if (($unsigned($random(seed)) % 4) == 0)
        h = lsq_pkg::hold_t'(4'($random(seed)));
      drive_cycle(($unsigned($random(seed)) % 2) == 0, h, ($unsigned($random(seed)) % 5) == 0,
                  '1);
    end
    drain();
    finish_test("holds_and_stalls");

    h = '0;
    h.miss_hold = 1'b1;
    acc0 = n_accepted;
    for (int i = 0; i < 12; i++)
      drive_cycle(1'b1, h, 1'b0, '1);
    compare_value("accepted", 160'(n_accepted - acc0), 160'(`LSQ_DEPTH));
    compare_value("do_stall", 160'(do_stall), 160'(1'b1));
    drain();
    finish_test("fill_and_drain");

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hw/lsq_pkg.sv
hw/store_queue.sv
hw/store_pick.sv
hw/store_lane.sv
hw/lsq_store_top.sv
test/tb_lsq_store.sv

//--- run.sh
#!/bin/sh
# build and run the store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f sim.f --top-module tb_lsq_store -o sim_lsq_store

out=$(./obj_dir/sim_lsq_store)
echo "$out"

# pass only if the pass line is in the output
echo "$out" | grep -q "^Finished with no errors$"
